// File: mips_mem_stage.f
hdl/mem_pkg.sv
hdl/mem_bypass.sv
hdl/except_resolve.sv
hdl/load_store_unit.sv
hdl/mem_stage.sv
verification/tb_mem_stage.sv

// File: run_sim.sh
#!/bin/sh
# builds the memory-stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mips_mem_stage.f \
    --top-module tb_mem_stage -o sim_mem_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_mem_stage)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// File: verification/tb_mem_stage.sv
// self-checking testbench for the memory-access stage and the simulation top module
module tb_mem_stage;

    localparam int GROUP_LEN = 400;
    localparam int NUM_GROUPS = 5;
    // five random groups plus reset, warm-up and drain
    localparam int CYCLE_LIMIT = NUM_GROUPS * GROUP_LEN + 200;

    logic clk = 1'b0;
    logic arst_n_i;
    mem_pkg::alu_op_e aluop_i;
    mem_pkg::word_t mem_addr_i;
    mem_pkg::word_t reg2_i;
    mem_pkg::reg_addr_t wd_i;
    logic wreg_i;
    mem_pkg::word_t wdata_i;
    mem_pkg::word_t excepttype_i;
    mem_pkg::word_t current_inst_address_i;
    mem_pkg::word_t mem_data_i;
    logic llbit_i;
    logic wb_llbit_we_i;
    logic wb_llbit_value_i;
    mem_pkg::word_t cp0_status_i;
    mem_pkg::word_t cp0_cause_i;
    mem_pkg::word_t cp0_epc_i;
    logic wb_cp0_reg_we_i;
    logic [mem_pkg::CP0_ADDR_W-1:0] wb_cp0_reg_write_addr_i;
    mem_pkg::word_t wb_cp0_reg_data_i;

    mem_pkg::word_t mem_addr_o;
    logic mem_we_o;
    mem_pkg::byte_sel_t mem_sel_o;
    mem_pkg::word_t mem_data_o;
    logic mem_ce_o;
    mem_pkg::reg_addr_t wd_o;
    logic wreg_o;
    mem_pkg::word_t wdata_o;
    logic llbit_we_o;
    logic llbit_value_o;
    mem_pkg::exc_code_e excepttype_o;
    mem_pkg::word_t cp0_epc_o;

    // expected values of the instruction in the combinational part
    mem_pkg::word_t exp_addr;
    logic exp_we;
    mem_pkg::byte_sel_t exp_sel;
    mem_pkg::word_t exp_data;
    logic exp_ce;
    mem_pkg::word_t exp_wdata;
    logic exp_llwe;
    logic exp_llval;
    mem_pkg::exc_code_e exp_exc;
    mem_pkg::word_t exp_epc;

    // packed writeback expectation of wd, wreg, wdata, llbit we and llbit value
    logic [39:0] wb_q[$];
    string name_q[$];
    logic [39:0] wb_exp;
    string wb_name;
    string test_name;

    logic [31:0] lfsr_q = 32'hb6dc_0225;
    int err_count = 0;
    int n_checks = 0;
    int cycle_count = 0;

    mem_stage i_dut (
        .clk                     (clk),
        .arst_n_i                (arst_n_i),
        .aluop_i                 (aluop_i),
        .mem_addr_i              (mem_addr_i),
        .reg2_i                  (reg2_i),
        .wd_i                    (wd_i),
        .wreg_i                  (wreg_i),
        .wdata_i                 (wdata_i),
        .excepttype_i            (excepttype_i),
        .current_inst_address_i  (current_inst_address_i),
        .mem_data_i              (mem_data_i),
        .llbit_i                 (llbit_i),
        .wb_llbit_we_i           (wb_llbit_we_i),
        .wb_llbit_value_i        (wb_llbit_value_i),
        .cp0_status_i            (cp0_status_i),
        .cp0_cause_i             (cp0_cause_i),
        .cp0_epc_i               (cp0_epc_i),
        .wb_cp0_reg_we_i         (wb_cp0_reg_we_i),
        .wb_cp0_reg_write_addr_i (wb_cp0_reg_write_addr_i),
        .wb_cp0_reg_data_i       (wb_cp0_reg_data_i),
        .mem_addr_o              (mem_addr_o),
        .mem_we_o                (mem_we_o),
        .mem_sel_o               (mem_sel_o),
        .mem_data_o              (mem_data_o),
        .mem_ce_o                (mem_ce_o),
        .wd_o                    (wd_o),
        .wreg_o                  (wreg_o),
        .wdata_o                 (wdata_o),
        .llbit_we_o              (llbit_we_o),
        .llbit_value_o           (llbit_value_o),
        .excepttype_o            (excepttype_o),
        .cp0_epc_o               (cp0_epc_o)
    );

    always #4 clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic mem_pkg::alu_op_e op_at(input int idx);
        case (idx)
            0: return mem_pkg::OP_LB;
            1: return mem_pkg::OP_LBU;
            2: return mem_pkg::OP_LH;
            3: return mem_pkg::OP_LHU;
            4: return mem_pkg::OP_LW;
            5: return mem_pkg::OP_SB;
            6: return mem_pkg::OP_SH;
            7: return mem_pkg::OP_SW;
            8: return mem_pkg::OP_LL;
            9: return mem_pkg::OP_SC;
            default: return mem_pkg::OP_NOP;
        endcase
    endfunction

    // byte at address offset k of a big-endian word
    function automatic logic [7:0] byte_at(input mem_pkg::word_t w, input int k);
        return 8'(w >> (8 * (3 - k)));
    endfunction

    function automatic void model_mem();
        mem_pkg::word_t status;
        mem_pkg::word_t cause;
        mem_pkg::word_t ld;
        logic link;
        int off;
        status = cp0_status_i;
        cause = cp0_cause_i;
        exp_epc = cp0_epc_i;
        if (wb_cp0_reg_we_i && wb_cp0_reg_write_addr_i == mem_pkg::CP0_STATUS) begin
            status = wb_cp0_reg_data_i;
        end
        if (wb_cp0_reg_we_i && wb_cp0_reg_write_addr_i == mem_pkg::CP0_CAUSE) begin
            // software writes only bits 9:8, 22 and 23 of cause
            cause[9:8] = wb_cp0_reg_data_i[9:8];
            cause[23:22] = wb_cp0_reg_data_i[23:22];
        end
        if (wb_cp0_reg_we_i && wb_cp0_reg_write_addr_i == mem_pkg::CP0_EPC) begin
            exp_epc = wb_cp0_reg_data_i;
        end
        exp_exc = mem_pkg::EXC_NONE;
        if (current_inst_address_i != 0) begin
            if ((|(cause[mem_pkg::IM_HI:mem_pkg::IM_LO] & status[mem_pkg::IM_HI:mem_pkg::IM_LO]))
                && status[mem_pkg::ST_IE] && !status[mem_pkg::ST_EXL]) begin
                exp_exc = mem_pkg::EXC_INT;
            end else if (excepttype_i[mem_pkg::EXC_BIT_SYSCALL]) begin
                exp_exc = mem_pkg::EXC_SYSCALL;
            end else if (excepttype_i[mem_pkg::EXC_BIT_INVALID]) begin
                exp_exc = mem_pkg::EXC_INVALID;
            end else if (excepttype_i[mem_pkg::EXC_BIT_TRAP]) begin
                exp_exc = mem_pkg::EXC_TRAP;
            end else if (excepttype_i[mem_pkg::EXC_BIT_OV]) begin
                exp_exc = mem_pkg::EXC_OV;
            end else if (excepttype_i[mem_pkg::EXC_BIT_ERET]) begin
                exp_exc = mem_pkg::EXC_ERET;
            end
        end

        link = wb_llbit_we_i ? wb_llbit_value_i : llbit_i;
        off = int'(mem_addr_i[1:0]);
        exp_ce = (aluop_i != mem_pkg::OP_NOP) && !(aluop_i == mem_pkg::OP_SC && !link);
        exp_addr = exp_ce ? mem_addr_i : '0;
        exp_we = 1'b0;
        exp_sel = 4'b1111;
        exp_data = '0;
        exp_wdata = wdata_i;
        exp_llwe = 1'b0;
        exp_llval = 1'b0;
        case (aluop_i)
            mem_pkg::OP_LB, mem_pkg::OP_LBU: begin
                exp_sel = mem_pkg::byte_sel_t'(4'b0001 << (3 - off));
                ld = {24'b0, byte_at(mem_data_i, off)};
                if (aluop_i == mem_pkg::OP_LB && ld[7]) begin
                    ld[31:8] = '1;
                end
                exp_wdata = ld;
            end
            mem_pkg::OP_LH, mem_pkg::OP_LHU: begin
                exp_wdata = '0;
                if (off == 0 || off == 2) begin
                    exp_sel = (off == 0) ? 4'b1100 : 4'b0011;
                    ld = {16'b0, byte_at(mem_data_i, off + 1), byte_at(mem_data_i, off)};
                    if (aluop_i == mem_pkg::OP_LH && ld[15]) begin
                        ld[31:16] = '1;
                    end
                    exp_wdata = ld;
                end
            end
            mem_pkg::OP_LW: begin
                exp_wdata = {byte_at(mem_data_i, 3), byte_at(mem_data_i, 2),
                             byte_at(mem_data_i, 1), byte_at(mem_data_i, 0)};
            end
            mem_pkg::OP_SB: begin
                exp_we = 1'b1;
                exp_sel = mem_pkg::byte_sel_t'(4'b0001 << (3 - off));
                exp_data = {4{reg2_i[7:0]}};
            end
            mem_pkg::OP_SH: begin
                exp_we = 1'b1;
                exp_sel = (off == 0) ? 4'b1100 : ((off == 2) ? 4'b0011 : 4'b0000);
                exp_data = {byte_at(reg2_i, 3), byte_at(reg2_i, 2),
                            byte_at(reg2_i, 3), byte_at(reg2_i, 2)};
            end
            mem_pkg::OP_SW: begin
                exp_we = 1'b1;
                exp_data = {byte_at(reg2_i, 3), byte_at(reg2_i, 2),
                            byte_at(reg2_i, 1), byte_at(reg2_i, 0)};
            end
            mem_pkg::OP_LL: begin
                exp_wdata = mem_data_i;
                exp_llwe = 1'b1;
                exp_llval = 1'b1;
            end
            mem_pkg::OP_SC: begin
                exp_wdata = link ? 32'd1 : 32'd0;
                exp_we = link;
                exp_llwe = link;
                exp_data = link ? reg2_i : '0;
            end
            default: begin
            end
        endcase
        // a raised exception cancels the store
        exp_we = exp_we && (exp_exc == mem_pkg::EXC_NONE);
    endfunction

    task automatic check_value(input string tname, input string field,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
        n_checks++;
        assert (exp_v === act_v) else begin
            err_count++;
            $display("ERR %s %s: expected %h, actual %h", tname, field, exp_v, act_v);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (arst_n_i) begin
            model_mem();
            check_value(test_name, "mem_ce", 32'(exp_ce), 32'(mem_ce_o));
            check_value(test_name, "mem_we", 32'(exp_we), 32'(mem_we_o));
            check_value(test_name, "mem_addr", exp_addr, mem_addr_o);
            check_value(test_name, "mem_sel", 32'(exp_sel), 32'(mem_sel_o));
            check_value(test_name, "mem_data", exp_data, mem_data_o);
            check_value(test_name, "excepttype", exp_exc, excepttype_o);
            check_value(test_name, "cp0_epc", exp_epc, cp0_epc_o);
            if (wb_q.size() == 0) begin
                check_value("reset", "wreg", 32'd0, 32'(wreg_o));
                check_value("reset", "llbit_we", 32'd0, 32'(llbit_we_o));
                check_value("reset", "wdata", 32'd0, wdata_o);
            end else begin
                wb_exp = wb_q.pop_front();
                wb_name = name_q.pop_front();
                check_value(wb_name, "wd", 32'(wb_exp[39:35]), 32'(wd_o));
                check_value(wb_name, "wreg", 32'(wb_exp[34]), 32'(wreg_o));
                check_value(wb_name, "wdata", wb_exp[33:2], wdata_o);
                check_value(wb_name, "llbit_we", 32'(wb_exp[1]), 32'(llbit_we_o));
                check_value(wb_name, "llbit_value", 32'(wb_exp[0]), 32'(llbit_value_o));
            end
            wb_q.push_back({wd_i, wreg_i, exp_wdata, exp_llwe, exp_llval});
            name_q.push_back(test_name);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing, %0d errors so far",
                     cycle_count, err_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // quiet defaults without exception or CP0 write
    task automatic drive_common(input string name);
        test_name <= name;
        wd_i <= mem_pkg::reg_addr_t'(rand_bits(5));
        wreg_i <= 1'(rand_bits(1));
        wdata_i <= rand_bits(32);
        reg2_i <= rand_bits(32);
        mem_data_i <= rand_bits(32);
        mem_addr_i <= rand_bits(32);
        current_inst_address_i <= rand_bits(32) | 32'h4;
        excepttype_i <= '0;
        llbit_i <= 1'(rand_bits(1));
        wb_llbit_we_i <= 1'b0;
        wb_llbit_value_i <= 1'b0;
        cp0_status_i <= '0;
        cp0_cause_i <= rand_bits(32);
        cp0_epc_i <= rand_bits(32);
        wb_cp0_reg_we_i <= 1'b0;
        wb_cp0_reg_write_addr_i <= '0;
        wb_cp0_reg_data_i <= rand_bits(32);
    endtask

    task automatic drive_exception_mix();
        logic [4:0] flags;
        drive_common("except");
        // sparse flags so the interrupt and none paths show up too
        flags = 5'(rand_bits(5)) & 5'(rand_bits(5));
        aluop_i <= op_at(int'(rand_bits(4) % 11));
        excepttype_i <= {19'b0, flags, 8'(rand_bits(8))};
        cp0_status_i <= rand_bits(32);
        wb_llbit_we_i <= 1'(rand_bits(1));
        wb_llbit_value_i <= 1'(rand_bits(1));
        wb_cp0_reg_we_i <= 1'(rand_bits(1));
        wb_cp0_reg_write_addr_i <= 5'(11 + int'(rand_bits(3) % 5));
        if (rand_bits(3) == 0) begin
            current_inst_address_i <= '0;
        end
    endtask

    task automatic drive_store_with_exception();
        logic [4:0] flags;
        drive_common("store_exc");
        flags = 5'(rand_bits(5));
        if (flags == 5'd0) begin
            flags = 5'd1;
        end
        aluop_i <= op_at(5 + int'(rand_bits(4) % 3));
        excepttype_i <= {19'b0, flags, 8'(rand_bits(8))};
    endtask

    initial begin
        arst_n_i <= 1'b0;
        test_name <= "reset";
        aluop_i <= mem_pkg::OP_NOP;
        mem_addr_i <= '0;
        reg2_i <= '0;
        wd_i <= '0;
        wreg_i <= 1'b0;
        wdata_i <= '0;
        excepttype_i <= '0;
        current_inst_address_i <= '0;
        mem_data_i <= '0;
        llbit_i <= 1'b0;
        wb_llbit_we_i <= 1'b0;
        wb_llbit_value_i <= 1'b0;
        cp0_status_i <= '0;
        cp0_cause_i <= '0;
        cp0_epc_i <= '0;
        wb_cp0_reg_we_i <= 1'b0;
        wb_cp0_reg_write_addr_i <= '0;
        wb_cp0_reg_data_i <= '0;
        repeat (2) @(posedge clk);
        arst_n_i <= 1'b1;

        repeat (4) begin
            @(posedge clk);
            drive_common("nop");
            aluop_i <= mem_pkg::OP_NOP;
        end
        repeat (GROUP_LEN) begin
            @(posedge clk);
            drive_common("load");
            aluop_i <= op_at(int'(rand_bits(4) % 5));
        end
        repeat (GROUP_LEN) begin
            @(posedge clk);
            drive_common("store");
            aluop_i <= op_at(5 + int'(rand_bits(4) % 3));
        end
        repeat (GROUP_LEN) begin
            @(posedge clk);
            drive_common("llsc");
            aluop_i <= op_at(8 + int'(rand_bits(1)));
            wb_llbit_we_i <= 1'(rand_bits(1));
            wb_llbit_value_i <= 1'(rand_bits(1));
        end
        repeat (GROUP_LEN) begin
            @(posedge clk);
            drive_exception_mix();
        end
        repeat (GROUP_LEN) begin
            @(posedge clk);
            drive_store_with_exception();
        end
        // let the last result reach the output register
        repeat (2) begin
            @(posedge clk);
            drive_common("drain");
            aluop_i <= mem_pkg::OP_NOP;
        end
        @(negedge clk);
        #1;
        $display("checks %0d, errors %0d", n_checks, err_count);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/mem_stage.sv
// memory-access pipeline stage, connects CP0/link bypass, exception resolution and load/store
module mem_stage (
    input  logic                              clk,
    input  logic                              arst_n_i,

    // from execute
    input  mem_pkg::alu_op_e                  aluop_i,
    input  mem_pkg::word_t                    mem_addr_i,
    input  mem_pkg::word_t                    reg2_i,
    input  mem_pkg::reg_addr_t                wd_i,
    input  logic                              wreg_i,
    input  mem_pkg::word_t                    wdata_i,
    input  mem_pkg::word_t                    excepttype_i,
    input  mem_pkg::word_t                    current_inst_address_i,

    // data memory read port
    input  mem_pkg::word_t                    mem_data_i,

    // link bit and its writeback bypass
    input  logic                              llbit_i,
    input  logic                              wb_llbit_we_i,
    input  logic                              wb_llbit_value_i,

    // CP0 state and writeback CP0 write
    input  mem_pkg::word_t                    cp0_status_i,
    input  mem_pkg::word_t                    cp0_cause_i,
    input  mem_pkg::word_t                    cp0_epc_i,
    input  logic                              wb_cp0_reg_we_i,
    input  logic [mem_pkg::CP0_ADDR_W-1:0]    wb_cp0_reg_write_addr_i,
    input  mem_pkg::word_t                    wb_cp0_reg_data_i,

    // data memory request
    output mem_pkg::word_t                    mem_addr_o,
    output logic                              mem_we_o,
    output mem_pkg::byte_sel_t                mem_sel_o,
    output mem_pkg::word_t                    mem_data_o,
    output logic                              mem_ce_o,

    // to writeback, one clock later
    output mem_pkg::reg_addr_t                wd_o,
    output logic                              wreg_o,
    output mem_pkg::word_t                    wdata_o,
    output logic                              llbit_we_o,
    output logic                              llbit_value_o,

    // to CP0
    output mem_pkg::exc_code_e                excepttype_o,
    output mem_pkg::word_t                    cp0_epc_o
);

    mem_pkg::word_t status_q;
    mem_pkg::word_t cause_q;
    logic llbit_q;

    mem_bypass u_mem_bypass (
        .llbit_i                 (llbit_i),
        .wb_llbit_we_i           (wb_llbit_we_i),
        .wb_llbit_value_i        (wb_llbit_value_i),
        .cp0_status_i            (cp0_status_i),
        .cp0_cause_i             (cp0_cause_i),
        .cp0_epc_i               (cp0_epc_i),
        .wb_cp0_reg_we_i         (wb_cp0_reg_we_i),
        .wb_cp0_reg_write_addr_i (wb_cp0_reg_write_addr_i),
        .wb_cp0_reg_data_i       (wb_cp0_reg_data_i),
        .status_o                (status_q),
        .cause_o                 (cause_q),
        .epc_o                   (cp0_epc_o),
        .llbit_o                 (llbit_q)
    );

    except_resolve u_except_resolve (
        .excepttype_i           (excepttype_i),
        .current_inst_address_i (current_inst_address_i),
        .status_i               (status_q),
        .cause_i                (cause_q),
        .excepttype_o           (excepttype_o)
    );

    load_store_unit u_load_store_unit (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .aluop_i       (aluop_i),
        .mem_addr_i    (mem_addr_i),
        .reg2_i        (reg2_i),
        .mem_data_i    (mem_data_i),
        .wd_i          (wd_i),
        .wreg_i        (wreg_i),
        .wdata_i       (wdata_i),
        .llbit_i       (llbit_q),
        .excepttype_i  (excepttype_o),
        .mem_addr_o    (mem_addr_o),
        .mem_we_o      (mem_we_o),
        .mem_sel_o     (mem_sel_o),
        .mem_data_o    (mem_data_o),
        .mem_ce_o      (mem_ce_o),
        .wd_o          (wd_o),
        .wreg_o        (wreg_o),
        .wdata_o       (wdata_o),
        .llbit_we_o    (llbit_we_o),
        .llbit_value_o (llbit_value_o)
    );

endmodule

// File: hdl/load_store_unit.sv
// drives the data-memory request, aligns load data, runs LL/SC and registers the writeback fields
module load_store_unit (
    input  logic                clk,
    input  logic                arst_n_i,
    input  mem_pkg::alu_op_e    aluop_i,
    input  mem_pkg::word_t      mem_addr_i,
    input  mem_pkg::word_t      reg2_i,
    input  mem_pkg::word_t      mem_data_i,
    input  mem_pkg::reg_addr_t  wd_i,
    input  logic                wreg_i,
    input  mem_pkg::word_t      wdata_i,
    input  logic                llbit_i,
    input  mem_pkg::exc_code_e  excepttype_i,
    output mem_pkg::word_t      mem_addr_o,
    output logic                mem_we_o,
    output mem_pkg::byte_sel_t  mem_sel_o,
    output mem_pkg::word_t      mem_data_o,
    output logic                mem_ce_o,
    output mem_pkg::reg_addr_t  wd_o,
    output logic                wreg_o,
    output mem_pkg::word_t      wdata_o,
    output logic                llbit_we_o,
    output logic                llbit_value_o
);

    logic [1:0] offset;
    logic [7:0] lane_byte;
    logic [15:0] lane_half;
    logic half_aligned;
    mem_pkg::byte_sel_t byte_sel;
    mem_pkg::byte_sel_t half_sel;
    logic mem_we;
    mem_pkg::word_t wdata_d;
    logic llbit_we_d;
    logic llbit_value_d;

    // memory is big-endian relative to the register file
    function automatic mem_pkg::word_t byte_swap(input mem_pkg::word_t w);
        byte_swap = {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign offset = mem_addr_i[1:0];

    // offset 0 is lane 3
    assign byte_sel = mem_pkg::byte_sel_t'(4'b1000 >> offset);
    assign half_sel = offset[1] ? 4'b0011 : 4'b1100;
    assign half_aligned = !offset[0];

    always_comb begin
        case (offset)
            2'b00: lane_byte = mem_data_i[31:24];
            2'b01: lane_byte = mem_data_i[23:16];
            2'b10: lane_byte = mem_data_i[15:8];
            default: lane_byte = mem_data_i[7:0];
        endcase
    end

    // lower-address byte ends up in the low byte
    assign lane_half = offset[1] ? {mem_data_i[7:0], mem_data_i[15:8]}
                                 : {mem_data_i[23:16], mem_data_i[31:24]};

    always_comb begin
        mem_addr_o = '0;
        mem_we = 1'b0;
        mem_sel_o = 4'b1111;
        mem_data_o = '0;
        mem_ce_o = 1'b0;
        wdata_d = wdata_i;
        llbit_we_d = 1'b0;
        llbit_value_d = 1'b0;
        case (aluop_i)
            mem_pkg::OP_LB, mem_pkg::OP_LBU: begin
                mem_addr_o = mem_addr_i;
                mem_ce_o = 1'b1;
                mem_sel_o = byte_sel;
                if (aluop_i == mem_pkg::OP_LB) begin
                    wdata_d = {{24{lane_byte[7]}}, lane_byte};
                end else begin
                    wdata_d = {24'b0, lane_byte};
                end
            end
            mem_pkg::OP_LH, mem_pkg::OP_LHU: begin
                mem_addr_o = mem_addr_i;
                mem_ce_o = 1'b1;
                if (!half_aligned) begin
                    // misaligned, keep the full select and load zero
                    wdata_d = '0;
                end else if (aluop_i == mem_pkg::OP_LH) begin
                    mem_sel_o = half_sel;
                    wdata_d = {{16{lane_half[15]}}, lane_half};
                end else begin
                    mem_sel_o = half_sel;
                    wdata_d = {16'b0, lane_half};
                end
            end
            mem_pkg::OP_LW: begin
                mem_addr_o = mem_addr_i;
                mem_ce_o = 1'b1;
                wdata_d = byte_swap(mem_data_i);
            end
            mem_pkg::OP_SB: begin
                mem_addr_o = mem_addr_i;
                mem_ce_o = 1'b1;
                mem_we = 1'b1;
                mem_sel_o = byte_sel;
                mem_data_o = {4{reg2_i[7:0]}};
            end
            mem_pkg::OP_SH: begin
                mem_addr_o = mem_addr_i;
                mem_ce_o = 1'b1;
                mem_we = 1'b1;
                mem_sel_o = half_aligned ? half_sel : 4'b0000;
                mem_data_o = {2{reg2_i[7:0], reg2_i[15:8]}};
            end
            mem_pkg::OP_SW: begin
                mem_addr_o = mem_addr_i;
                mem_ce_o = 1'b1;
                mem_we = 1'b1;
                mem_data_o = byte_swap(reg2_i);
            end
            mem_pkg::OP_LL: begin
                mem_addr_o = mem_addr_i;
                mem_ce_o = 1'b1;
                wdata_d = mem_data_i;
                llbit_we_d = 1'b1;
                llbit_value_d = 1'b1;
            end
            mem_pkg::OP_SC: begin
                // fails quietly without touching memory if the link was lost
                if (llbit_i) begin
                    mem_addr_o = mem_addr_i;
                    mem_ce_o = 1'b1;
                    mem_we = 1'b1;
                    mem_data_o = reg2_i;
                    wdata_d = 32'd1;
                    llbit_we_d = 1'b1;
                end else begin
                    wdata_d = '0;
                end
            end
            default: begin
            end
        endcase
    end

    // an exception in this stage cancels the write
    assign mem_we_o = mem_we && (excepttype_i == mem_pkg::EXC_NONE);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wd_o <= '0;
            wreg_o <= 1'b0;
            wdata_o <= '0;
            llbit_we_o <= 1'b0;
            llbit_value_o <= 1'b0;
        end else begin
            wd_o <= wd_i;
            wreg_o <= wreg_i;
            wdata_o <= wdata_d;
            llbit_we_o <= llbit_we_d;
            llbit_value_o <= llbit_value_d;
        end
    end

endmodule

// File: hdl/except_resolve.sv
// reduces the raw exception flags and pending interrupts to one exception code by priority
module except_resolve (
    input  mem_pkg::word_t     excepttype_i,
    input  mem_pkg::word_t     current_inst_address_i,
    input  mem_pkg::word_t     status_i,
    input  mem_pkg::word_t     cause_i,
    output mem_pkg::exc_code_e excepttype_o
);

    logic [mem_pkg::IM_HI-mem_pkg::IM_LO:0] pending_irq;
    logic irq_enabled;
    logic irq_taken;
    logic is_bubble;

    // interrupt lines that are both raised and unmasked
    assign pending_irq = cause_i[mem_pkg::IM_HI:mem_pkg::IM_LO] &
                         status_i[mem_pkg::IM_HI:mem_pkg::IM_LO];

    // no interrupt while already at exception level
    assign irq_enabled = status_i[mem_pkg::ST_IE] && !status_i[mem_pkg::ST_EXL];
    assign irq_taken = (|pending_irq) && irq_enabled;

    // a zero address marks a bubble, nothing is raised for it
    assign is_bubble = (current_inst_address_i == '0);

    always_comb begin
        excepttype_o = mem_pkg::EXC_NONE;
        if (!is_bubble) begin
            if (irq_taken) begin
                excepttype_o = mem_pkg::EXC_INT;
            end else if (excepttype_i[mem_pkg::EXC_BIT_SYSCALL]) begin
                excepttype_o = mem_pkg::EXC_SYSCALL;
            end else if (excepttype_i[mem_pkg::EXC_BIT_INVALID]) begin
                excepttype_o = mem_pkg::EXC_INVALID;
            end else if (excepttype_i[mem_pkg::EXC_BIT_TRAP]) begin
                excepttype_o = mem_pkg::EXC_TRAP;
            end else if (excepttype_i[mem_pkg::EXC_BIT_OV]) begin
                excepttype_o = mem_pkg::EXC_OV;
            end else if (excepttype_i[mem_pkg::EXC_BIT_ERET]) begin
                excepttype_o = mem_pkg::EXC_ERET;
            end
        end
    end

endmodule

// File: hdl/mem_bypass.sv
// forwards a same-cycle writeback write of Status, Cause, EPC or the link bit to the stage
module mem_bypass (
    input  logic                              llbit_i,
    input  logic                              wb_llbit_we_i,
    input  logic                              wb_llbit_value_i,
    input  mem_pkg::word_t                    cp0_status_i,
    input  mem_pkg::word_t                    cp0_cause_i,
    input  mem_pkg::word_t                    cp0_epc_i,
    input  logic                              wb_cp0_reg_we_i,
    input  logic [mem_pkg::CP0_ADDR_W-1:0]    wb_cp0_reg_write_addr_i,
    input  mem_pkg::word_t                    wb_cp0_reg_data_i,
    output mem_pkg::word_t                    status_o,
    output mem_pkg::word_t                    cause_o,
    output mem_pkg::word_t                    epc_o,
    output logic                              llbit_o
);

    logic wr_status;
    logic wr_cause;
    logic wr_epc;
    mem_pkg::word_t cause_merged;

    // which CP0 register writeback touches this cycle
    assign wr_status = wb_cp0_reg_we_i && (wb_cp0_reg_write_addr_i == mem_pkg::CP0_STATUS);
    assign wr_cause = wb_cp0_reg_we_i && (wb_cp0_reg_write_addr_i == mem_pkg::CP0_CAUSE);
    assign wr_epc = wb_cp0_reg_we_i && (wb_cp0_reg_write_addr_i == mem_pkg::CP0_EPC);

    // only a few cause bits are writable, the rest stay hardware-owned
    assign cause_merged = (cp0_cause_i & ~mem_pkg::CAUSE_WR_MASK) |
                          (wb_cp0_reg_data_i & mem_pkg::CAUSE_WR_MASK);

    always_comb begin
        if (wr_status) begin
            status_o = wb_cp0_reg_data_i;
        end else begin
            status_o = cp0_status_i;
        end
    end

    always_comb begin
        if (wr_cause) begin
            cause_o = cause_merged;
        end else begin
            cause_o = cp0_cause_i;
        end
    end

    always_comb begin
        if (wr_epc) begin
            epc_o = wb_cp0_reg_data_i;
        end else begin
            epc_o = cp0_epc_i;
        end
    end

    // newest link bit, an LL or SC in writeback wins
    assign llbit_o = wb_llbit_we_i ? wb_llbit_value_i : llbit_i;

endmodule

// File: hdl/mem_pkg.sv
// shared widths, data types, opcodes and CP0 field positions for the memory-access stage
package mem_pkg;

    localparam int DATA_W = 32;
    localparam int SEL_W = 4;
    localparam int REG_ADDR_W = 5;
    localparam int CP0_ADDR_W = 5;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    // bit 3 is the lane of memory bits 31:24
    typedef logic [SEL_W-1:0] byte_sel_t;

    // opcodes as issued by the execute stage
    typedef enum logic [7:0] {
        OP_NOP = 8'b0000_0000,
        OP_LB  = 8'b1110_0000,
        OP_LBU = 8'b1110_0100,
        OP_LH  = 8'b1110_0001,
        OP_LHU = 8'b1110_0101,
        OP_LW  = 8'b1110_0011,
        OP_SB  = 8'b1110_1000,
        OP_SH  = 8'b1110_1001,
        OP_SW  = 8'b1110_1011,
        OP_LL  = 8'b1111_0000,
        OP_SC  = 8'b1111_1000
    } alu_op_e;

    typedef enum logic [31:0] {
        EXC_NONE    = 32'd0,
        EXC_INT     = 32'd1,
        EXC_SYSCALL = 32'd8,
        EXC_INVALID = 32'd10,
        EXC_OV      = 32'd12,
        EXC_TRAP    = 32'd13,
        EXC_ERET    = 32'd14
    } exc_code_e;

    // raw flag positions in the exception vector from execute
    localparam int EXC_BIT_SYSCALL = 8;
    localparam int EXC_BIT_INVALID = 9;
    localparam int EXC_BIT_TRAP = 10;
    localparam int EXC_BIT_OV = 11;
    localparam int EXC_BIT_ERET = 12;

    // CP0 register numbers
    localparam logic [CP0_ADDR_W-1:0] CP0_STATUS = 5'd12;
    localparam logic [CP0_ADDR_W-1:0] CP0_CAUSE = 5'd13;
    localparam logic [CP0_ADDR_W-1:0] CP0_EPC = 5'd14;

    // status fields, IP in cause sits at the same 15:8
    localparam int ST_IE = 0;
    localparam int ST_EXL = 1;
    localparam int IM_HI = 15;
    localparam int IM_LO = 8;

    // software-writable cause bits: IP[1:0], WP and IV
    localparam word_t CAUSE_WR_MASK = 32'h00C0_0300;

endpackage
